/* tb.f */
design/rv_pkg.sv
design/if_stage.sv
design/id_stage.sv
design/ex_stage.sv
design/mem_stage.sv
design/regfile.sv
design/rv_core.sv
verif/rv_core_chk.sv
verif/tb_rv_core.sv

/* Makefile */
TOP = tb_rv_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

/* verif/tb_rv_core.sv */
// tb_rv_core: directed tests for the multicycle rv64i core with an APB data memory
`timescale 1ns/1ps

module tb_rv_core;

  // base opcodes from the rv64i encoding
  localparam logic [6:0]  opc_lui   = 7'b0110111;
  localparam logic [6:0]  opc_auipc = 7'b0010111;
  localparam logic [6:0]  opc_jalr  = 7'b1100111;
  localparam logic [6:0]  opc_load  = 7'b0000011;
  localparam logic [6:0]  opc_imm   = 7'b0010011;
  localparam logic [6:0]  opc_reg   = 7'b0110011;
  localparam logic [6:0]  opc_imm32 = 7'b0011011;
  localparam logic [6:0]  opc_reg32 = 7'b0111011;
  localparam logic [31:0] nop_word  = 32'h00000013;
  localparam int          retire_timeout = 40;

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  logic [63:0] imem_addr;
  logic [31:0] imem_data = 32'h0;
  logic [63:0] paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [63:0] pwdata;
  logic [7:0]  pstrb;
  logic [63:0] prdata = 64'h0;
  logic        pready = 1'b0;
  logic        retire_valid;
  logic [63:0] retire_pc;
  logic [4:0]  retire_rd;
  logic [63:0] retire_data;

  logic [31:0] rom [0:63];
  logic [63:0] dmem [0:63];
  logic [63:0] cycle_count = 64'h0;
  logic [63:0] last_retire = 64'h0;
  logic [7:0]  last_strb = 8'h0;
  logic        first_retire = 1'b1;
  int          max_wait = 0;
  int          wait_left = 0;
  int          waits_taken = 0;

  rv_core dut (.*);

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 64'd1;
  end

  // instruction rom and APB slave, both answered on the falling edge
  always @(negedge clk) begin
    imem_data = rom[imem_addr[7:2]];
    pready    = 1'b0;
    if (psel && !penable) begin
      wait_left   = $urandom % (max_wait + 1);
      waits_taken = wait_left;
    end else if (psel && penable) begin
      if (wait_left > 0) begin
        wait_left--;
      end else begin
        pready = 1'b1;
        if (pwrite) begin
          last_strb = pstrb;
          for (int b = 0; b < 8; b++) begin
            if (pstrb[b]) begin
              dmem[paddr[8:3]][8*b +: 8] = pwdata[8*b +: 8];
            end
          end
        end else begin
          prdata = dmem[paddr[8:3]];
        end
      end
    end
  end

  function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] stype_word(input logic [11:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] btype_word(input logic [12:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jal_word(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [63:0] sext12(input logic [11:0] v);
    return {{52{v[11]}}, v};
  endfunction

  function automatic logic [63:0] sext32(input logic [63:0] v);
    return {{32{v[31]}}, v[31:0]};
  endfunction

  function automatic logic [63:0] upper_imm(input logic [19:0] v);
    return {{32{v[19]}}, v, 12'h000};
  endfunction

  task automatic abort_run();
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input logic [rv_pkg::xlen-1:0] got,
      input logic [rv_pkg::xlen-1:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_reg(input string name, input logic [rv_pkg::reg_addr_w-1:0] got,
      input logic [rv_pkg::reg_addr_w-1:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_phase_e(input string name, input rv_pkg::phase_e got,
      input rv_pkg::phase_e exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %s expected %s", $time, name, got.name(), exp.name());
      abort_run();
    end
  endtask

  task automatic expect_retire(input logic [63:0] exp_pc, input logic [4:0] exp_rd,
      input logic [63:0] exp_data, input bit is_mem);
    int          n;
    logic [63:0] gap;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!retire_valid && n < retire_timeout);
    if (!retire_valid) begin
      $display("no retire pulse within %0d cycles, waiting for pc %h", retire_timeout, exp_pc);
      abort_run();
    end
    gap = cycle_count - last_retire;
    last_retire = cycle_count;
    check_data("retire_pc", retire_pc, exp_pc);
    check_reg("retire_rd", retire_rd, exp_rd);
    if (exp_rd != 5'd0) begin
      check_data("retire_data", retire_data, exp_data);
    end
    // memory ops add a setup cycle plus the slave wait cycles
    if (!first_retire) begin
      check_data("retire spacing", gap, is_mem ? 64'd6 + 64'(waits_taken) : 64'd5);
    end
    first_retire = 1'b0;
  endtask

  task automatic begin_reset();
    @(negedge clk);
    rst = 1'b1;
    for (int i = 0; i < 64; i++) begin
      rom[i] = nop_word;
    end
  endtask

  task automatic end_reset();
    repeat (8) @(negedge clk);
    rst = 1'b0;
    first_retire = 1'b1;
    check_phase_e("phase", dut.u_if.phase, rv_pkg::ph_fetch);
    check_data("psel", {63'd0, psel}, 64'd0);
    check_data("retire_valid", {63'd0, retire_valid}, 64'd0);
  endtask

  task automatic alu_ops();
    logic [11:0] i1;
    logic [11:0] i2;
    logic [5:0]  sh;
    logic [63:0] x1;
    logic [63:0] x2;
    logic [63:0] x7;
    i1 = 12'($urandom);
    i2 = 12'($urandom);
    sh = 6'($urandom);
    x1 = sext12(i1);
    x2 = sext12(i2);
    x7 = upper_imm(20'h80000);
    begin_reset();
    rom[0]  = itype_word(i1, 5'd0, 3'b000, 5'd1, opc_imm);
    rom[1]  = itype_word(i2, 5'd0, 3'b000, 5'd2, opc_imm);
    rom[2]  = rtype_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, opc_reg);
    rom[3]  = rtype_word(7'h20, 5'd2, 5'd1, 3'b000, 5'd4, opc_reg);
    rom[4]  = itype_word({6'd0, sh}, 5'd1, 3'b001, 5'd5, opc_imm);
    rom[5]  = itype_word({6'd0, sh}, 5'd4, 3'b101, 5'd6, opc_imm);
    rom[6]  = {20'h80000, 5'd7, opc_lui};
    rom[7]  = rtype_word(7'h00, 5'd7, 5'd1, 3'b000, 5'd8, opc_reg32);
    rom[8]  = itype_word(12'hfff, 5'd7, 3'b000, 5'd9, opc_imm32);
    // write to x0, then read it back through an add
    rom[9]  = itype_word(12'd5, 5'd1, 3'b000, 5'd0, opc_imm);
    rom[10] = rtype_word(7'h00, 5'd0, 5'd0, 3'b000, 5'd10, opc_reg);
    end_reset();
    expect_retire(64'd0, 5'd1, x1, 1'b0);
    expect_retire(64'd4, 5'd2, x2, 1'b0);
    expect_retire(64'd8, 5'd3, x1 + x2, 1'b0);
    expect_retire(64'd12, 5'd4, x1 - x2, 1'b0);
    expect_retire(64'd16, 5'd5, x1 << sh, 1'b0);
    expect_retire(64'd20, 5'd6, (x1 - x2) >> sh, 1'b0);
    expect_retire(64'd24, 5'd7, x7, 1'b0);
    expect_retire(64'd28, 5'd8, sext32(x1 + x7), 1'b0);
    expect_retire(64'd32, 5'd9, sext32(x7 - 64'd1), 1'b0);
    expect_retire(64'd36, 5'd0, 64'd0, 1'b0);
    expect_retire(64'd40, 5'd10, 64'd0, 1'b0);
  endtask

  task automatic upper_immediates();
    logic [19:0] u1;
    logic [19:0] u2;
    u1 = 20'($urandom);
    u2 = 20'($urandom);
    begin_reset();
    rom[0] = {u1, 5'd1, opc_lui};
    rom[1] = {u2, 5'd2, opc_auipc};
    end_reset();
    expect_retire(64'd0, 5'd1, upper_imm(u1), 1'b0);
    expect_retire(64'd4, 5'd2, 64'd4 + upper_imm(u2), 1'b0);
  endtask

  task automatic jumps_and_branches();
    begin_reset();
    rom[0]  = jal_word(21'd16, 5'd1);
    rom[4]  = itype_word(12'd24, 5'd0, 3'b000, 5'd5, opc_imm);
    rom[5]  = itype_word(12'd8, 5'd5, 3'b000, 5'd2, opc_jalr);
    rom[8]  = btype_word(13'd12, 5'd0, 5'd0, 3'b000);
    rom[11] = btype_word(13'd12, 5'd0, 5'd0, 3'b001);
    rom[12] = btype_word(13'd8, 5'd0, 5'd5, 3'b001);
    rom[14] = btype_word(13'd8, 5'd0, 5'd5, 3'b000);
    rom[15] = itype_word(12'd1, 5'd0, 3'b000, 5'd6, opc_imm);
    end_reset();
    expect_retire(64'd0, 5'd1, 64'd4, 1'b0);
    expect_retire(64'd16, 5'd5, 64'd24, 1'b0);
    expect_retire(64'd20, 5'd2, 64'd24, 1'b0);
    // beq taken, bne not taken, bne taken, beq not taken
    expect_retire(64'd32, 5'd0, 64'd0, 1'b0);
    expect_retire(64'd44, 5'd0, 64'd0, 1'b0);
    expect_retire(64'd48, 5'd0, 64'd0, 1'b0);
    expect_retire(64'd56, 5'd0, 64'd0, 1'b0);
    expect_retire(64'd60, 5'd6, 64'd1, 1'b0);
  endtask

  task automatic load_store(input int waits);
    logic [63:0] d0;
    logic [63:0] old;
    max_wait = waits;
    d0  = {$urandom, $urandom};
    old = {$urandom, $urandom};
    begin_reset();
    dmem[8]  = d0;
    dmem[10] = old;
    rom[0] = itype_word(12'd64, 5'd0, 3'b000, 5'd1, opc_imm);
    rom[1] = itype_word(12'd0, 5'd1, 3'b011, 5'd2, opc_load);
    rom[2] = stype_word(12'd8, 5'd2, 5'd1, 3'b011);
    rom[3] = itype_word(12'd8, 5'd1, 3'b011, 5'd3, opc_load);
    rom[4] = stype_word(12'd16, 5'd2, 5'd1, 3'b010);
    rom[5] = itype_word(12'd16, 5'd1, 3'b011, 5'd4, opc_load);
    end_reset();
    expect_retire(64'd0, 5'd1, 64'd64, 1'b0);
    expect_retire(64'd4, 5'd2, d0, 1'b1);
    expect_retire(64'd8, 5'd0, 64'd0, 1'b1);
    check_data("slave pstrb for sd", {56'd0, last_strb}, 64'hff);
    expect_retire(64'd12, 5'd3, d0, 1'b1);
    expect_retire(64'd16, 5'd0, 64'd0, 1'b1);
    check_data("slave pstrb for sw", {56'd0, last_strb}, 64'h0f);
    // sw leaves the upper word of the old value in place
    expect_retire(64'd20, 5'd4, {old[63:32], d0[31:0]}, 1'b1);
    check_data("dmem[9]", dmem[9], d0);
    check_data("dmem[10]", dmem[10], {old[63:32], d0[31:0]});
  endtask

  initial begin
    void'($urandom(32'hfb55));
    for (int i = 0; i < 64; i++) begin
      dmem[i] = {32'(i) * 32'h9e3779b9, ~32'(i)};
    end
    alu_ops();
    upper_immediates();
    jumps_and_branches();
    load_store(0);
    load_store(3);
    if (dut.u_mem.u_chk.fail_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* verif/rv_core_chk.sv */
// rv_core_chk: APB master protocol and phase checks bound into the memory stage
`timescale 1ns/1ps

module rv_core_chk (
  input logic                    clk,
  input logic                    rst,
  input rv_pkg::phase_e          phase,
  input logic                    psel,
  input logic                    penable,
  input logic                    pready,
  input logic                    pwrite,
  input logic [rv_pkg::xlen-1:0] paddr,
  input logic [rv_pkg::xlen-1:0] pwdata,
  input logic [7:0]              pstrb
);

  int fail_count = 0;

  // access cycle only after a setup cycle
  a_setup_first: assert property (@(posedge clk) disable iff (rst)
    $rose(penable) |-> $past(psel) && !$past(penable))
    else begin
      $error("penable rose without a preceding setup cycle");
      fail_count++;
    end

  // setup and stalled access keep the transfer frozen
  a_hold_stable: assert property (@(posedge clk) disable iff (rst)
    (psel && !(penable && pready)) |=> psel && penable && $stable(paddr) &&
      $stable(pwrite) && $stable(pwdata) && $stable(pstrb))
    else begin
      $error("APB transfer changed before pready");
      fail_count++;
    end

  a_psel_in_mem: assert property (@(posedge clk) disable iff (rst)
    $rose(psel) |-> (phase == rv_pkg::ph_mem))
    else begin
      $error("psel rose outside the memory phase");
      fail_count++;
    end

endmodule

bind mem_stage rv_core_chk u_chk (
  .clk     (clk),
  .rst     (rst),
  .phase   (phase),
  .psel    (psel),
  .penable (penable),
  .pready  (pready),
  .pwrite  (pwrite),
  .paddr   (paddr),
  .pwdata  (pwdata),
  .pstrb   (pstrb)
);

/* design/rv_core.sv */
// rv_core: multicycle rv64i core top, stage instances and interconnect
`timescale 1ns/1ps

module rv_core (
  input  logic                          clk,
  input  logic                          rst,
  output logic [rv_pkg::xlen-1:0]       imem_addr,
  input  logic [rv_pkg::ilen-1:0]       imem_data,
  output logic [rv_pkg::xlen-1:0]       paddr,
  output logic                          psel,
  output logic                          penable,
  output logic                          pwrite,
  output logic [rv_pkg::xlen-1:0]       pwdata,
  output logic [7:0]                    pstrb,
  input  logic [rv_pkg::xlen-1:0]       prdata,
  input  logic                          pready,
  output logic                          retire_valid,
  output logic [rv_pkg::xlen-1:0]       retire_pc,
  output logic [rv_pkg::reg_addr_w-1:0] retire_rd,
  output logic [rv_pkg::xlen-1:0]       retire_data
);

  rv_pkg::phase_e                phase;
  rv_pkg::alu_op_e               alu_op;
  logic [rv_pkg::xlen-1:0]       pc;
  logic [rv_pkg::xlen-1:0]       next_pc;
  logic [rv_pkg::ilen-1:0]       inst;
  logic [rv_pkg::reg_addr_w-1:0] rs1;
  logic [rv_pkg::reg_addr_w-1:0] rs2;
  logic [rv_pkg::reg_addr_w-1:0] rd;
  logic [rv_pkg::xlen-1:0]       rs1_data;
  logic [rv_pkg::xlen-1:0]       rs2_data;
  logic [rv_pkg::xlen-1:0]       op1;
  logic [rv_pkg::xlen-1:0]       op2;
  logic [rv_pkg::xlen-1:0]       branch_target;
  logic [rv_pkg::xlen-1:0]       link_value;
  logic [rv_pkg::xlen-1:0]       alu_result;
  logic [rv_pkg::xlen-1:0]       mem_wdata;
  logic [rv_pkg::xlen-1:0]       wb_data;
  logic [7:0]                    mem_wstrb;
  logic [2:0]                    funct3;
  logic                          reg_wen;
  logic                          is_branch;
  logic                          is_jump;
  logic                          mem_ren;
  logic                          mem_wen;
  logic                          mem_busy;

  if_stage  u_if  (.*);
  id_stage  u_id  (.*);
  ex_stage  u_ex  (.*);
  mem_stage u_mem (.*);
  regfile   u_rf  (.*, .wen(reg_wen), .wdata(wb_data));

  // retire trace taps
  assign retire_pc   = pc;
  assign retire_rd   = rd;
  assign retire_data = wb_data;

endmodule

/* design/regfile.sv */
// regfile: 32 x 64-bit integer registers, two read ports, one write port
`timescale 1ns/1ps

module regfile (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [rv_pkg::reg_addr_w-1:0] rs1,
  input  logic [rv_pkg::reg_addr_w-1:0] rs2,
  input  logic [rv_pkg::reg_addr_w-1:0] rd,
  input  logic                          wen,
  input  logic [rv_pkg::xlen-1:0]       wdata,
  output logic [rv_pkg::xlen-1:0]       rs1_data,
  output logic [rv_pkg::xlen-1:0]       rs2_data
);

  // x0 has no storage
  logic [rv_pkg::xlen-1:0] regs [1:31];

  always_ff @(posedge clk) begin
    if (!rst && wen && (rd != '0)) begin
      regs[rd] <= wdata;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* design/mem_stage.sv */
// mem_stage: APB master for data loads and stores, and writeback data select
`timescale 1ns/1ps

module mem_stage (
  input  logic                    clk,
  input  logic                    rst,
  input  rv_pkg::phase_e          phase,
  input  logic                    mem_ren,
  input  logic                    mem_wen,
  input  logic [rv_pkg::xlen-1:0] alu_result,
  input  logic [rv_pkg::xlen-1:0] mem_wdata,
  input  logic [7:0]              mem_wstrb,
  output logic [rv_pkg::xlen-1:0] paddr,
  output logic                    psel,
  output logic                    penable,
  output logic                    pwrite,
  output logic [rv_pkg::xlen-1:0] pwdata,
  output logic [7:0]              pstrb,
  input  logic [rv_pkg::xlen-1:0] prdata,
  input  logic                    pready,
  output logic                    mem_busy,
  output logic [rv_pkg::xlen-1:0] wb_data
);

  logic [rv_pkg::xlen-1:0] rdata_q;
  logic                    access_done;

  assign access_done = psel && penable && pready;

  // setup cycle lands on the first ph_mem cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      psel    <= 1'b0;
      penable <= 1'b0;
    end else if (access_done) begin
      psel    <= 1'b0;
      penable <= 1'b0;
    end else if (psel) begin
      penable <= 1'b1;
    end else if ((phase == rv_pkg::ph_exec) && (mem_ren || mem_wen)) begin
      psel <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (access_done && !pwrite) begin
      rdata_q <= prdata;
    end
  end

  // sources only change in decode and exec, so these hold through the transfer
  assign paddr  = alu_result;
  assign pwrite = mem_wen;
  assign pwdata = mem_wdata;
  assign pstrb  = mem_wen ? mem_wstrb : 8'h00;

  assign mem_busy = psel && !(penable && pready);

  always_comb begin
    if (!mem_ren) begin
      wb_data = alu_result;
    end else if (mem_wstrb == rv_pkg::strb_word) begin
      wb_data = {{32{rdata_q[31]}}, rdata_q[31:0]};
    end else begin
      wb_data = rdata_q;
    end
  end

endmodule

/* design/ex_stage.sv */
// ex_stage: ALU, branch resolution and next pc selection
`timescale 1ns/1ps

module ex_stage (
  input  logic                    clk,
  input  logic                    rst,
  input  rv_pkg::phase_e          phase,
  input  logic [rv_pkg::xlen-1:0] pc,
  input  logic [rv_pkg::xlen-1:0] op1,
  input  logic [rv_pkg::xlen-1:0] op2,
  input  rv_pkg::alu_op_e         alu_op,
  input  logic [2:0]              funct3,
  input  logic                    is_branch,
  input  logic                    is_jump,
  input  logic [rv_pkg::xlen-1:0] branch_target,
  input  logic [rv_pkg::xlen-1:0] link_value,
  output logic [rv_pkg::xlen-1:0] alu_result,
  output logic [rv_pkg::xlen-1:0] next_pc
);

  logic [rv_pkg::xlen-1:0] sum;
  logic [rv_pkg::xlen-1:0] result;
  logic                    taken;
  logic                    exec;

  assign exec = (phase == rv_pkg::ph_exec);
  assign sum  = op1 + op2;

  always_comb begin
    case (alu_op)
      rv_pkg::alu_add:  result = sum;
      rv_pkg::alu_sub:  result = op1 - op2;
      rv_pkg::alu_sll:  result = op1 << op2[5:0];
      rv_pkg::alu_srl:  result = op1 >> op2[5:0];
      // w forms keep the low word, sign extended
      rv_pkg::alu_addw: result = {{32{sum[31]}}, sum[31:0]};
      // jumps write the return address
      rv_pkg::alu_pass: result = link_value;
      default:          result = sum;
    endcase
  end

  always_comb begin
    taken = 1'b0;
    if (is_branch) begin
      case (funct3)
        rv_pkg::f3_beq: taken = (op1 == op2);
        rv_pkg::f3_bne: taken = (op1 != op2);
        default:        taken = 1'b0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      next_pc <= rv_pkg::reset_pc;
    end else if (exec) begin
      next_pc <= (taken || is_jump) ? branch_target : pc + 64'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (exec) begin
      alu_result <= result;
    end
  end

endmodule

/* design/id_stage.sv */
// id_stage: instruction decode, immediate build, operand and memory control setup
`timescale 1ns/1ps

module id_stage (
  input  logic                          clk,
  input  logic                          rst,
  input  rv_pkg::phase_e                phase,
  input  logic [rv_pkg::ilen-1:0]       inst,
  input  logic [rv_pkg::xlen-1:0]       pc,
  input  logic [rv_pkg::xlen-1:0]       rs1_data,
  input  logic [rv_pkg::xlen-1:0]       rs2_data,
  output logic [rv_pkg::reg_addr_w-1:0] rs1,
  output logic [rv_pkg::reg_addr_w-1:0] rs2,
  output logic [rv_pkg::reg_addr_w-1:0] rd,
  output logic [rv_pkg::xlen-1:0]       op1,
  output logic [rv_pkg::xlen-1:0]       op2,
  output logic [rv_pkg::xlen-1:0]       branch_target,
  output logic [rv_pkg::xlen-1:0]       link_value,
  output rv_pkg::alu_op_e               alu_op,
  output logic                          reg_wen,
  output logic                          is_branch,
  output logic                          is_jump,
  output logic [2:0]                    funct3,
  output logic                          mem_ren,
  output logic                          mem_wen,
  output logic [rv_pkg::xlen-1:0]       mem_wdata,
  output logic [7:0]                    mem_wstrb
);

  rv_pkg::opcode_e         opcode;
  rv_pkg::itype_e          itype;
  rv_pkg::alu_op_e         alu_op_d;
  logic [2:0]              f3;
  logic [rv_pkg::xlen-1:0] imm;
  logic [rv_pkg::xlen-1:0] shamt_64;
  logic [rv_pkg::xlen-1:0] op1_d;
  logic [rv_pkg::xlen-1:0] op2_d;
  logic [rv_pkg::xlen-1:0] target_d;
  logic [7:0]              wstrb_d;
  logic                    decoding;
  logic                    is_shift;
  logic                    wen_d;
  logic                    wen_q;

  assign decoding = (phase == rv_pkg::ph_decode);
  assign opcode   = rv_pkg::opcode_e'(inst[6:2]);
  assign f3       = inst[14:12];
  assign shamt_64 = {58'd0, inst[25:20]};
  assign is_shift = (opcode == rv_pkg::op_imm) &&
                    ((f3 == rv_pkg::f3_sll) || (f3 == rv_pkg::f3_srl));

  // fence, ecall and csr ops fall to it_none and retire as nops
  always_comb begin
    case (opcode)
      rv_pkg::op_lui, rv_pkg::op_auipc:  itype = rv_pkg::it_u;
      rv_pkg::op_jal:                    itype = rv_pkg::it_j;
      rv_pkg::op_jalr, rv_pkg::op_load,
      rv_pkg::op_imm, rv_pkg::op_imm32:  itype = rv_pkg::it_i;
      rv_pkg::op_branch:                 itype = rv_pkg::it_b;
      rv_pkg::op_store:                  itype = rv_pkg::it_s;
      rv_pkg::op_reg, rv_pkg::op_reg32:  itype = rv_pkg::it_r;
      default:                           itype = rv_pkg::it_none;
    endcase
  end

  always_comb begin
    case (itype)
      rv_pkg::it_i: imm = {{52{inst[31]}}, inst[31:20]};
      rv_pkg::it_s: imm = {{52{inst[31]}}, inst[31:25], inst[11:7]};
      rv_pkg::it_b: imm = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      rv_pkg::it_u: imm = {{32{inst[31]}}, inst[31:12], 12'd0};
      rv_pkg::it_j: imm = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      default:      imm = '0;
    endcase
  end

  // register reads only for formats that use them
  assign rs1 = (decoding && (itype inside {rv_pkg::it_r, rv_pkg::it_i,
                rv_pkg::it_s, rv_pkg::it_b})) ? inst[19:15] : '0;
  assign rs2 = (decoding && (itype inside {rv_pkg::it_r, rv_pkg::it_s,
                rv_pkg::it_b})) ? inst[24:20] : '0;

  always_comb begin
    op1_d = rs1_data;
    op2_d = imm;
    case (itype)
      rv_pkg::it_r, rv_pkg::it_b: op2_d = rs2_data;
      rv_pkg::it_i:               op2_d = is_shift ? shamt_64 : imm;
      // lui adds to zero, auipc to the pc
      rv_pkg::it_u:               op1_d = (opcode == rv_pkg::op_auipc) ? pc : '0;
      rv_pkg::it_j:               op1_d = '0;
      default:                    op2_d = imm;
    endcase
  end

  always_comb begin
    alu_op_d = rv_pkg::alu_add;
    case (opcode)
      rv_pkg::op_reg, rv_pkg::op_imm: begin
        if (f3 == rv_pkg::f3_sll) begin
          alu_op_d = rv_pkg::alu_sll;
        end else if (f3 == rv_pkg::f3_srl) begin
          alu_op_d = rv_pkg::alu_srl;
        end else if ((opcode == rv_pkg::op_reg) && inst[30]) begin
          alu_op_d = rv_pkg::alu_sub;
        end
      end
      rv_pkg::op_reg32, rv_pkg::op_imm32: alu_op_d = rv_pkg::alu_addw;
      rv_pkg::op_jal, rv_pkg::op_jalr:    alu_op_d = rv_pkg::alu_pass;
      default:                            alu_op_d = rv_pkg::alu_add;
    endcase
  end

  // jalr clears bit 0 of the computed target
  assign target_d = (opcode == rv_pkg::op_jalr) ? ((rs1_data + imm) & ~64'd1) : (pc + imm);

  assign wen_d = itype inside {rv_pkg::it_r, rv_pkg::it_i, rv_pkg::it_u, rv_pkg::it_j};

  // strobe also marks the load width
  always_comb begin
    wstrb_d = 8'h00;
    if ((opcode == rv_pkg::op_load) || (opcode == rv_pkg::op_store)) begin
      if (f3 == rv_pkg::f3_sd) begin
        wstrb_d = rv_pkg::strb_dword;
      end else if (f3 == rv_pkg::f3_sw) begin
        wstrb_d = rv_pkg::strb_word;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd        <= '0;
      alu_op    <= rv_pkg::alu_add;
      wen_q     <= 1'b0;
      is_branch <= 1'b0;
      is_jump   <= 1'b0;
      mem_ren   <= 1'b0;
      mem_wen   <= 1'b0;
    end else if (decoding) begin
      rd        <= wen_d ? inst[11:7] : '0;
      alu_op    <= alu_op_d;
      wen_q     <= wen_d;
      is_branch <= (opcode == rv_pkg::op_branch);
      is_jump   <= (opcode == rv_pkg::op_jal) || (opcode == rv_pkg::op_jalr);
      mem_ren   <= (opcode == rv_pkg::op_load);
      mem_wen   <= (opcode == rv_pkg::op_store);
    end
  end

  always_ff @(posedge clk) begin
    if (decoding) begin
      op1           <= op1_d;
      op2           <= op2_d;
      branch_target <= target_d;
      link_value    <= pc + 64'd4;
      funct3        <= f3;
      mem_wdata     <= rs2_data;
      mem_wstrb     <= wstrb_d;
    end
  end

  // write only in writeback
  assign reg_wen = wen_q && (phase == rv_pkg::ph_wb);

endmodule

/* design/if_stage.sv */
// if_stage: phase sequencer, program counter and instruction latch
`timescale 1ns/1ps

module if_stage (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    mem_busy,
  input  logic [rv_pkg::xlen-1:0] next_pc,
  input  logic [rv_pkg::ilen-1:0] imem_data,
  output rv_pkg::phase_e          phase,
  output logic [rv_pkg::xlen-1:0] pc,
  output logic [rv_pkg::xlen-1:0] imem_addr,
  output logic [rv_pkg::ilen-1:0] inst,
  output logic                    retire_valid
);

  rv_pkg::phase_e phase_nxt;

  always_comb begin
    case (phase)
      rv_pkg::ph_fetch:  phase_nxt = rv_pkg::ph_decode;
      rv_pkg::ph_decode: phase_nxt = rv_pkg::ph_exec;
      rv_pkg::ph_exec:   phase_nxt = rv_pkg::ph_mem;
      // stay here until the apb transfer completes
      rv_pkg::ph_mem:    phase_nxt = mem_busy ? rv_pkg::ph_mem : rv_pkg::ph_wb;
      default:           phase_nxt = rv_pkg::ph_fetch;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      phase <= rv_pkg::ph_fetch;
      pc    <= rv_pkg::reset_pc;
    end else begin
      phase <= phase_nxt;
      if (phase == rv_pkg::ph_wb) begin
        pc <= next_pc;
      end
    end
  end

  // imem answers in the same cycle
  always_ff @(posedge clk) begin
    if (phase == rv_pkg::ph_fetch) begin
      inst <= imem_data;
    end
  end

  assign imem_addr    = (phase == rv_pkg::ph_fetch) ? pc : '0;
  assign retire_valid = (phase == rv_pkg::ph_wb);

endmodule

/* design/rv_pkg.sv */
// rv_pkg: shared widths, instruction encodings and sequencer states for the rv64i core
package rv_pkg;

  localparam int xlen       = 64;
  localparam int ilen       = 32;
  localparam int reg_addr_w = 5;

  localparam logic [xlen-1:0] reset_pc = 64'h0;

  // major opcode, taken from inst[6:2]
  typedef enum logic [4:0] {
    op_load   = 5'b00000,
    op_misc   = 5'b00011,
    op_imm    = 5'b00100,
    op_auipc  = 5'b00101,
    op_imm32  = 5'b00110,
    op_store  = 5'b01000,
    op_reg    = 5'b01100,
    op_lui    = 5'b01101,
    op_reg32  = 5'b01110,
    op_branch = 5'b11000,
    op_jalr   = 5'b11001,
    op_jal    = 5'b11011
  } opcode_e;

  // instruction format
  typedef enum logic [2:0] {
    it_r,
    it_i,
    it_s,
    it_b,
    it_u,
    it_j,
    it_none
  } itype_e;

  // one stage active per cycle
  typedef enum logic [2:0] {
    ph_fetch,
    ph_decode,
    ph_exec,
    ph_mem,
    ph_wb
  } phase_e;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_srl,
    alu_pass,
    alu_addw
  } alu_op_e;

  // funct3 codes; loads share the width codes with stores
  localparam logic [2:0] f3_beq = 3'b000;
  localparam logic [2:0] f3_bne = 3'b001;
  localparam logic [2:0] f3_sw  = 3'b010;
  localparam logic [2:0] f3_sd  = 3'b011;
  localparam logic [2:0] f3_sll = 3'b001;
  localparam logic [2:0] f3_srl = 3'b101;

  // byte strobes for word and doubleword accesses
  localparam logic [7:0] strb_word  = 8'h0f;
  localparam logic [7:0] strb_dword = 8'hff;

endpackage
